// ==== gpu_core.f ====
hdl/core_pkg.sv
hdl/core_scheduler.sv
hdl/fetcher.sv
hdl/decoder.sv
hdl/pc_counter.sv
hdl/register_alu.sv
hdl/gpu_core.sv
tb/gpu_core_asserts.sv
tb/gpu_core_tb.sv

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Bus and storage widths
    localparam int ADDR_W    = 8;
    localparam int INSTR_W   = 16;
    localparam int DATA_W    = 8;
    localparam int REG_IDX_W = 4;
    localparam int NZP_W     = 3;
    localparam int OPCODE_W  = 4;
    localparam int STATE_W   = 3;
    localparam int NUM_REGS  = 16;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [NZP_W-1:0]     nzp_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;

    typedef enum logic [STATE_W-1:0] {
        CORE_IDLE    = 3'd0,
        CORE_FETCH   = 3'd1,
        CORE_DECODE  = 3'd2,
        CORE_EXECUTE = 3'd3,
        CORE_UPDATE  = 3'd4,
        CORE_DONE    = 3'd5
    } core_state_t;

    typedef enum logic [STATE_W-1:0] {
        FETCHER_IDLE     = 3'd0,
        FETCHER_FETCHING = 3'd1,
        FETCHER_FETCHED  = 3'd2
    } fetcher_state_t;

    localparam opcode_t OP_NOP   = 4'd0;
    localparam opcode_t OP_BRNZP = 4'd1;
    localparam opcode_t OP_CMP   = 4'd2;
    localparam opcode_t OP_ADD   = 4'd3;
    localparam opcode_t OP_SUB   = 4'd4;
    localparam opcode_t OP_MUL   = 4'd5;
    localparam opcode_t OP_CONST = 4'd9;
    localparam opcode_t OP_STR   = 4'd10;
    localparam opcode_t OP_RET   = 4'd15;

    // Flag encoding, bit 2 is negative and matches mask bit 11
    localparam nzp_t NZP_NEG  = 3'b100;
    localparam nzp_t NZP_ZERO = 3'b010;
    localparam nzp_t NZP_POS  = 3'b001;

    // Instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 8;
    localparam int RS_MSB     = 7;
    localparam int RS_LSB     = 4;
    localparam int RT_MSB     = 3;
    localparam int RT_LSB     = 0;
    localparam int IMM_MSB    = 7;
    localparam int IMM_LSB    = 0;
    localparam int NZP_MSB    = 11;
    localparam int NZP_LSB    = 9;

endpackage

`default_nettype wire

// ==== hdl/core_scheduler.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_scheduler (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            start,
    input  wire core_pkg::fetcher_state_t  fetcher_state,
    input  wire                            decoded_ret,
    input  wire                            store_done,
    output core_pkg::core_state_t          core_state,
    output logic                           done
);

    core_pkg::core_state_t state_next;

    always_comb begin
        state_next = core_state;
        case (core_state)
            core_pkg::CORE_IDLE: begin
                if (start) begin
                    state_next = core_pkg::CORE_FETCH;
                end
            end
            core_pkg::CORE_FETCH: begin
                // Wait here for as long as program memory takes
                if (fetcher_state == core_pkg::FETCHER_FETCHED) begin
                    state_next = core_pkg::CORE_DECODE;
                end
            end
            core_pkg::CORE_DECODE: begin
                state_next = core_pkg::CORE_EXECUTE;
            end
            core_pkg::CORE_EXECUTE: begin
                // RET ends the program, otherwise wait for the store phase
                if (decoded_ret) begin
                    state_next = core_pkg::CORE_DONE;
                end else if (store_done) begin
                    state_next = core_pkg::CORE_UPDATE;
                end
            end
            core_pkg::CORE_UPDATE: begin
                state_next = core_pkg::CORE_FETCH;
            end
            core_pkg::CORE_DONE: begin
                state_next = core_pkg::CORE_DONE;
            end
            default: begin
                state_next = core_pkg::CORE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state <= core_pkg::CORE_IDLE;
        end else begin
            core_state <= state_next;
        end
    end

    assign done = (core_state == core_pkg::CORE_DONE);

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module decoder (
    input  wire                         clk,
    input  wire                         reset,
    input  wire core_pkg::core_state_t  core_state,
    input  wire core_pkg::instr_t       instruction,

    output core_pkg::reg_idx_t          rd,
    output core_pkg::reg_idx_t          rs,
    output core_pkg::reg_idx_t          rt,
    output core_pkg::data_t             imm,
    output core_pkg::nzp_t              nzp_mask,

    output logic                        reg_write_enable,
    output core_pkg::opcode_t           alu_select,
    output logic                        nzp_write_enable,
    output logic                        pc_branch,
    output logic                        store_enable,
    output logic                        decoded_ret
);

    core_pkg::opcode_t opcode;
    logic              decode_now;

    assign opcode     = instruction[core_pkg::OPCODE_MSB:core_pkg::OPCODE_LSB];
    assign decode_now = (core_state == core_pkg::CORE_DECODE);

    // Instruction fields
    always_ff @(posedge clk) begin
        if (decode_now) begin
            rd         <= instruction[core_pkg::RD_MSB:core_pkg::RD_LSB];
            rs         <= instruction[core_pkg::RS_MSB:core_pkg::RS_LSB];
            rt         <= instruction[core_pkg::RT_MSB:core_pkg::RT_LSB];
            imm        <= instruction[core_pkg::IMM_MSB:core_pkg::IMM_LSB];
            nzp_mask   <= instruction[core_pkg::NZP_MSB:core_pkg::NZP_LSB];
            alu_select <= opcode;
        end
    end

    // Control lines, at most one set per instruction; unknown opcodes set none
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_enable <= 1'b0;
            nzp_write_enable <= 1'b0;
            pc_branch        <= 1'b0;
            store_enable     <= 1'b0;
            decoded_ret      <= 1'b0;
        end else if (decode_now) begin
            reg_write_enable <= (opcode == core_pkg::OP_ADD) || (opcode == core_pkg::OP_SUB)
                                || (opcode == core_pkg::OP_MUL)
                                || (opcode == core_pkg::OP_CONST);
            nzp_write_enable <= (opcode == core_pkg::OP_CMP);
            pc_branch        <= (opcode == core_pkg::OP_BRNZP);
            store_enable     <= (opcode == core_pkg::OP_STR);
            decoded_ret      <= (opcode == core_pkg::OP_RET);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetcher.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetcher (
    input  wire                         clk,
    input  wire                         reset,
    input  wire core_pkg::core_state_t  core_state,
    input  wire core_pkg::addr_t        current_pc,

    // Program memory read port
    output logic                        mem_read_valid,
    output core_pkg::addr_t             mem_read_address,
    input  wire                         mem_read_ready,
    input  wire core_pkg::instr_t       mem_read_data,

    output core_pkg::fetcher_state_t    fetcher_state,
    output core_pkg::instr_t            instruction
);

    logic issue_read;
    logic take_data;

    assign issue_read = (fetcher_state == core_pkg::FETCHER_IDLE)
                        && (core_state == core_pkg::CORE_FETCH);
    assign take_data  = (fetcher_state == core_pkg::FETCHER_FETCHING) && mem_read_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetcher_state  <= core_pkg::FETCHER_IDLE;
            mem_read_valid <= 1'b0;
        end else begin
            case (fetcher_state)
                core_pkg::FETCHER_IDLE: begin
                    if (issue_read) begin
                        fetcher_state  <= core_pkg::FETCHER_FETCHING;
                        mem_read_valid <= 1'b1;
                    end
                end
                core_pkg::FETCHER_FETCHING: begin
                    // Valid drops right after the transfer
                    if (take_data) begin
                        fetcher_state  <= core_pkg::FETCHER_FETCHED;
                        mem_read_valid <= 1'b0;
                    end
                end
                core_pkg::FETCHER_FETCHED: begin
                    if (core_state == core_pkg::CORE_DECODE) begin
                        fetcher_state <= core_pkg::FETCHER_IDLE;
                    end
                end
                default: begin
                    fetcher_state  <= core_pkg::FETCHER_IDLE;
                    mem_read_valid <= 1'b0;
                end
            endcase
        end
    end

    // Address and instruction word
    always_ff @(posedge clk) begin
        if (issue_read) begin
            mem_read_address <= current_pc;
        end
        if (take_data) begin
            instruction <= mem_read_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_core (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,

    // Program memory
    output logic                    mem_read_valid,
    output core_pkg::addr_t         mem_read_address,
    input  wire                     mem_read_ready,
    input  wire core_pkg::instr_t   mem_read_data,

    // Store port
    output logic                    store_valid,
    output core_pkg::data_t         store_data,
    input  wire                     store_ready,

    output logic                    done
);

    core_pkg::core_state_t    core_state;
    core_pkg::fetcher_state_t fetcher_state;
    core_pkg::instr_t         instruction;
    core_pkg::addr_t          current_pc;

    core_pkg::reg_idx_t       rd;
    core_pkg::reg_idx_t       rs;
    core_pkg::reg_idx_t       rt;
    core_pkg::data_t          imm;
    core_pkg::nzp_t           nzp_mask;
    core_pkg::opcode_t        alu_select;
    core_pkg::nzp_t           alu_nzp;

    logic reg_write_enable;
    logic nzp_write_enable;
    logic pc_branch;
    logic store_enable;
    logic decoded_ret;
    logic store_done;

    core_scheduler core_scheduler_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .fetcher_state (fetcher_state),
        .decoded_ret   (decoded_ret),
        .store_done    (store_done),
        .core_state    (core_state),
        .done          (done)
    );

    fetcher fetcher_i (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .current_pc       (current_pc),
        .mem_read_valid   (mem_read_valid),
        .mem_read_address (mem_read_address),
        .mem_read_ready   (mem_read_ready),
        .mem_read_data    (mem_read_data),
        .fetcher_state    (fetcher_state),
        .instruction      (instruction)
    );

    decoder decoder_i (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .instruction      (instruction),
        .rd               (rd),
        .rs               (rs),
        .rt               (rt),
        .imm              (imm),
        .nzp_mask         (nzp_mask),
        .reg_write_enable (reg_write_enable),
        .alu_select       (alu_select),
        .nzp_write_enable (nzp_write_enable),
        .pc_branch        (pc_branch),
        .store_enable     (store_enable),
        .decoded_ret      (decoded_ret)
    );

    pc_counter pc_counter_i (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .pc_branch        (pc_branch),
        .nzp_mask         (nzp_mask),
        .imm              (imm),
        .nzp_write_enable (nzp_write_enable),
        .alu_nzp          (alu_nzp),
        .current_pc       (current_pc)
    );

    register_alu register_alu_i (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .rd               (rd),
        .rs               (rs),
        .rt               (rt),
        .imm              (imm),
        .reg_write_enable (reg_write_enable),
        .alu_select       (alu_select),
        .store_enable     (store_enable),
        .alu_nzp          (alu_nzp),
        .store_valid      (store_valid),
        .store_data       (store_data),
        .store_ready      (store_ready),
        .store_done       (store_done)
    );

endmodule

`default_nettype wire

// ==== hdl/pc_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module pc_counter (
    input  wire                         clk,
    input  wire                         reset,
    input  wire core_pkg::core_state_t  core_state,
    input  wire                         pc_branch,
    input  wire core_pkg::nzp_t         nzp_mask,
    input  wire core_pkg::data_t        imm,
    input  wire                         nzp_write_enable,
    input  wire core_pkg::nzp_t         alu_nzp,
    output core_pkg::addr_t             current_pc
);

    core_pkg::nzp_t nzp;
    logic           branch_taken;

    assign branch_taken = pc_branch && ((nzp_mask & nzp) != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            nzp        <= '0;
            current_pc <= '0;
        end else begin
            // Flags come from CMP during execute
            if (core_state == core_pkg::CORE_EXECUTE && nzp_write_enable) begin
                nzp <= alu_nzp;
            end
            if (core_state == core_pkg::CORE_UPDATE) begin
                if (branch_taken) begin
                    current_pc <= core_pkg::addr_t'(imm);
                end else begin
                    // Wraps at the top of program memory
                    current_pc <= current_pc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/register_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module register_alu (
    input  wire                         clk,
    input  wire                         reset,
    input  wire core_pkg::core_state_t  core_state,
    input  wire core_pkg::reg_idx_t     rd,
    input  wire core_pkg::reg_idx_t     rs,
    input  wire core_pkg::reg_idx_t     rt,
    input  wire core_pkg::data_t        imm,
    input  wire                         reg_write_enable,
    input  wire core_pkg::opcode_t      alu_select,
    input  wire                         store_enable,
    output core_pkg::nzp_t              alu_nzp,

    // Store port
    output logic                        store_valid,
    output core_pkg::data_t             store_data,
    input  wire                         store_ready,
    output logic                        store_done
);

    core_pkg::data_t regs [core_pkg::NUM_REGS];
    core_pkg::data_t rs_val;
    core_pkg::data_t rt_val;
    core_pkg::data_t result;

    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    always_comb begin
        case (alu_select)
            core_pkg::OP_ADD:   result = rs_val + rt_val;
            core_pkg::OP_SUB:   result = rs_val - rt_val;
            core_pkg::OP_MUL:   result = rs_val * rt_val;
            core_pkg::OP_CONST: result = imm;
            default:            result = '0;
        endcase
    end

    // Signed compare of rs against rt for CMP
    always_comb begin
        if ($signed(rs_val) < $signed(rt_val)) begin
            alu_nzp = core_pkg::NZP_NEG;
        end else if (rs_val == rt_val) begin
            alu_nzp = core_pkg::NZP_ZERO;
        end else begin
            alu_nzp = core_pkg::NZP_POS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (core_state == core_pkg::CORE_UPDATE && reg_write_enable) begin
            regs[rd] <= result;
        end
    end

    // Valid stays up through execute until the sink takes the value
    assign store_valid = (core_state == core_pkg::CORE_EXECUTE) && store_enable;
    assign store_data  = rs_val;

    // Also high for an execute that has nothing to store
    assign store_done = (core_state == core_pkg::CORE_EXECUTE)
                        && (!store_enable || store_ready);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build gpu_core_tb with Verilator, run it and look for the pass message in its output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module gpu_core_tb \
        -f gpu_core.f -o gpu_core_sim \
    && sim_out=$(./obj_dir/gpu_core_sim +verilator+error+limit+100; true) \
    && printf '%s\n' "$sim_out" \
    && printf '%s\n' "$sim_out" | grep -q "Test completed successfully" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb/gpu_core_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_core_asserts (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     mem_read_valid,
    input  wire core_pkg::addr_t    mem_read_address,
    input  wire                     mem_read_ready,
    input  wire                     store_valid,
    input  wire core_pkg::data_t    store_data,
    input  wire                     store_ready,
    input  wire                     done
);

    int unsigned address_fails = 0;
    int unsigned read_drop_fails = 0;
    int unsigned store_hold_fails = 0;
    int unsigned done_fails = 0;
    int unsigned reset_fails = 0;

    // Total seen by the testbench at the end of the run
    int unsigned fail_count;

    assign fail_count = address_fails + read_drop_fails + store_hold_fails
                        + done_fails + reset_fails;

    // Read request and address hold until memory answers
    address_hold: assert property (@(posedge clk) disable iff (reset)
        mem_read_valid && !mem_read_ready |=> mem_read_valid && $stable(mem_read_address))
    else begin
        $error("mem_read_valid dropped or mem_read_address moved before ready");
        address_fails++;
    end

    read_drop: assert property (@(posedge clk) disable iff (reset)
        mem_read_valid && mem_read_ready |=> !mem_read_valid)
    else begin
        $error("mem_read_valid still high in the cycle after the transfer");
        read_drop_fails++;
    end

    // A pending store keeps its value until the sink takes it
    store_hold: assert property (@(posedge clk) disable iff (reset)
        store_valid && !store_ready |=> store_valid && $stable(store_data))
    else begin
        $error("store_valid dropped or store_data moved before store_ready");
        store_hold_fails++;
    end

    done_hold: assert property (@(posedge clk) disable iff (reset) done |=> done)
    else begin
        $error("done fell without a reset");
        done_fails++;
    end

    reset_quiet: assert property (@(posedge clk)
        reset |=> !mem_read_valid && !store_valid && !done)
    else begin
        $error("valid or done high in the cycle after reset");
        reset_fails++;
    end

endmodule

bind gpu_core gpu_core_asserts gpu_core_asserts_i (
    .clk              (clk),
    .reset            (reset),
    .mem_read_valid   (mem_read_valid),
    .mem_read_address (mem_read_address),
    .mem_read_ready   (mem_read_ready),
    .store_valid      (store_valid),
    .store_data       (store_data),
    .store_ready      (store_ready),
    .done             (done)
);

`default_nettype wire

// ==== tb/gpu_core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_core_tb;

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 3;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int MAX_REF_STEPS    = 1000;
    localparam int QUIET_CYCLES     = 6;

    logic             clk = 1'b0;
    logic             reset;
    logic             start;
    logic             mem_read_valid;
    core_pkg::addr_t  mem_read_address;
    logic             mem_read_ready = 1'b0;
    core_pkg::instr_t mem_read_data = '0;
    logic             store_valid;
    core_pkg::data_t  store_data;
    logic             store_ready = 1'b0;
    logic             done;

    core_pkg::instr_t program_mem [256];
    core_pkg::data_t  expected_stores [$];
    int unsigned      lcg_state = 77;
    int               read_wait = 0;
    int               executed_count = 0;
    int               timeout_limit = 0;
    int               cycles = 0;
    int               stores_seen = 0;
    int               value_errors = 0;
    int               seq_errors = 0;
    int               missing_stores = 0;
    int unsigned      protocol_errors = 0;
    logic             timed_out = 1'b0;

    gpu_core gpu_core_i (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .mem_read_valid   (mem_read_valid),
        .mem_read_address (mem_read_address),
        .mem_read_ready   (mem_read_ready),
        .mem_read_data    (mem_read_data),
        .store_valid      (store_valid),
        .store_data       (store_data),
        .store_ready      (store_ready),
        .done             (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic load_program();
        // Unused words are RET with the low address byte as payload
        for (int a = 0; a < 256; a++) begin
            program_mem[a] = {core_pkg::OP_RET, 4'h0, 8'(a)};
        end
        program_mem[0]  = 16'h9105;  // Loop counter r1 = 5
        program_mem[1]  = 16'h9201;  // r2 = 1
        program_mem[2]  = 16'h9300;  // r3 = 0
        program_mem[3]  = 16'h9407;  // r4 = 7
        program_mem[4]  = 16'hA040;  // store r4
        program_mem[5]  = 16'h95C8;  // r5 = 200
        program_mem[6]  = 16'h3645;  // r6 = r4 + r5
        program_mem[7]  = 16'hA060;
        program_mem[8]  = 16'h4745;  // r7 = r4 - r5
        program_mem[9]  = 16'hA070;
        program_mem[10] = 16'h5854;  // r8 = r5 * r4
        program_mem[11] = 16'hA080;
        // Countdown loop stores r1 while it stays positive
        program_mem[12] = 16'hA010;
        program_mem[13] = 16'h4112;
        program_mem[14] = 16'h2013;
        program_mem[15] = 16'h120C;
        program_mem[16] = 16'hF000;
    endtask

    // Instruction set model that yields the expected store sequence
    task automatic build_expected();
        core_pkg::data_t  regs [16];
        core_pkg::addr_t  pc;
        core_pkg::nzp_t   flags;
        core_pkg::instr_t word;
        core_pkg::data_t  imm;
        logic [3:0]       op;
        logic [3:0]       rd;
        logic [3:0]       rs;
        logic [3:0]       rt;
        logic             halted;
        pc = '0;
        flags = '0;
        halted = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        while (!halted && executed_count < MAX_REF_STEPS) begin
            word = program_mem[pc];
            op = word[15:12];
            rd = word[11:8];
            rs = word[7:4];
            rt = word[3:0];
            imm = word[7:0];
            executed_count++;
            case (op)
                core_pkg::OP_CONST: regs[rd] = imm;
                core_pkg::OP_ADD:   regs[rd] = regs[rs] + regs[rt];
                core_pkg::OP_SUB:   regs[rd] = regs[rs] - regs[rt];
                core_pkg::OP_MUL:   regs[rd] = regs[rs] * regs[rt];
                core_pkg::OP_STR:   expected_stores.push_back(regs[rs]);
                core_pkg::OP_RET:   halted = 1'b1;
                core_pkg::OP_CMP: begin
                    if ($signed(regs[rs]) < $signed(regs[rt])) begin
                        flags = 3'b100;
                    end else if (regs[rs] == regs[rt]) begin
                        flags = 3'b010;
                    end else begin
                        flags = 3'b001;
                    end
                end
                default: begin
                end
            endcase
            if (op == core_pkg::OP_BRNZP && (word[11:9] & flags) != 3'b000) begin
                pc = imm;
            end else begin
                pc = pc + 8'd1;
            end
        end
    endtask

    // Memory answers after 0 to 3 cycles of wait
    task automatic drive_memory(input logic reset_held);
        if (reset_held) begin
            mem_read_ready = 1'b0;
            read_wait = 0;
        end else if (mem_read_valid && !mem_read_ready) begin
            if (read_wait == 0) begin
                mem_read_ready = 1'b1;
                mem_read_data = program_mem[mem_read_address];
            end else begin
                read_wait--;
            end
        end else begin
            mem_read_ready = 1'b0;
            read_wait = int'(next_rand() % 4);
        end
    endtask

    task automatic drive_store_sink(input logic reset_held);
        if (reset_held) begin
            store_ready = 1'b0;
        end else begin
            // Ready about two cycles in three
            store_ready = (next_rand() % 3) != 0;
        end
    endtask

    task automatic check_store(input core_pkg::data_t value);
        core_pkg::data_t expected;
        if (stores_seen >= expected_stores.size()) begin
            seq_errors++;
            $display("Extra store of 0x%02h after all expected stores", value);
        end else begin
            expected = expected_stores[stores_seen];
            assert (value == expected) else begin
                value_errors++;
                $display("FAIL store_data: got 0x%02h, expected 0x%02h", value, expected);
            end
        end
        stores_seen++;
    endtask

    always @(posedge clk) begin
        logic reset_at_edge;
        reset_at_edge = reset;
        #1;
        drive_memory(reset_at_edge);
        drive_store_sink(reset_at_edge);
    end

    // Both sides of the store port are settled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (store_valid && store_ready) begin
                check_store(store_data);
            end
            assert (!(done && (mem_read_valid || store_valid))) else begin
                seq_errors++;
                $display("Read or store request after done at %0t", $time);
            end
        end
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        load_program();
        build_expected();
        timeout_limit = CYCLES_PER_INSTR * executed_count;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;

        while (!done && cycles < timeout_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end

        if (!done) begin
            timed_out = 1'b1;
            $display("Timeout: done not raised within %0d cycles", timeout_limit);
        end else begin
            // Stay a while to catch activity after done
            repeat (QUIET_CYCLES) @(posedge clk);
            #1;
            if (stores_seen < expected_stores.size()) begin
                missing_stores = expected_stores.size() - stores_seen;
                $display("Missing stores: %0d of %0d never arrived",
                         missing_stores, expected_stores.size());
            end
        end

        protocol_errors = gpu_core_i.gpu_core_asserts_i.fail_count;
        $display("Errors: value %0d, sequence %0d, missing %0d, protocol %0d, timeout %0d",
                 value_errors, seq_errors, missing_stores, protocol_errors, timed_out);
        if (timed_out || value_errors != 0 || seq_errors != 0 || missing_stores != 0
            || protocol_errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire
